// File: Makefile
# Verilator flow for the MM2S read engine

SIM_BIN = obj_dir/mm2s_sim

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --top-module mm2s_top -f flist.f

sim:
	verilator --binary --timing --top-module mm2s_tb -f flist.f -o mm2s_sim
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf obj_dir

// File: dv/axi_mem_model.sv
/*
	Read-only AXI slave memory model with a stall input for random
	r_valid gaps and an address window that answers with SLVERR
*/
`timescale 1ns/1ps
`default_nettype none

module axi_mem_model (
	input logic clk,
	input logic rst_n,
	input logic stall,
	input logic [mm2s_pkg::ADDR_W-1:0] err_lo,
	input logic [mm2s_pkg::ADDR_W-1:0] err_hi,
	input mm2s_pkg::ar_req_t ar,
	input logic ar_valid,
	output logic ar_ready,
	output mm2s_pkg::r_beat_t r,
	output logic r_valid,
	input logic r_ready
);
	import mm2s_pkg::*;

	logic active;
	logic [ADDR_W-1:0] cur_addr;
	logic [8:0] left;

	// Every address byte folds into the fill value
	function automatic logic [7:0] fill_byte(input logic [ADDR_W-1:0] a);
		return a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ 8'h5A;
	endfunction

	// One burst at a time
	assign ar_ready = !active;

	always_comb begin
		for (int j = 0; j < LANES; j++) begin
			r.data[8*j +: 8] = fill_byte(cur_addr + ADDR_W'(j));
		end
		r.resp = (cur_addr >= err_lo && cur_addr < err_hi) ? 2'b10 : 2'b00;
		r.last = (left == 9'd1);
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			active <= 1'b0;
			r_valid <= 1'b0;
			cur_addr <= '0;
			left <= '0;
		end else if (!active) begin
			if (ar_valid) begin
				active <= 1'b1;
				cur_addr <= {ar.addr[ADDR_W-1:LANE_W], {LANE_W{1'b0}}};
				left <= {1'b0, ar.len} + 9'd1;
			end
		end else if (r_valid && r_ready) begin
			cur_addr <= cur_addr + ADDR_W'(LANES);
			left <= left - 9'd1;
			r_valid <= (left != 9'd1) && !stall;
			if (left == 9'd1) begin
				active <= 1'b0;
			end
		end else if (!r_valid) begin
			// Valid stays up until taken
			r_valid <= !stall;
		end
	end

endmodule

`default_nettype wire

// File: dv/mm2s_tb.sv
/*
	MM2S read engine testbench: directed transfers against the AXI
	memory model, checking stream bytes, strobes, last, bursts and response
*/
`timescale 1ns/1ps
`default_nettype none

module mm2s_tb;
	import mm2s_pkg::*;

	localparam int MAX_BURST = 15;
	localparam int FIFO_DEPTH = 16;
	// About 180 read beats in all, a few thousand cycles even under heavy stalls
	localparam int TIMEOUT_CYCLES = 20000;

	logic clk;
	logic rst_n;
	logic trigger;
	logic [ADDR_W-1:0] start_addr;
	logic [LEN_W-1:0] bytes_to_read;
	logic busy;
	mm2s_resp_e response;
	ar_req_t ar;
	logic ar_valid;
	logic ar_ready;
	r_beat_t r;
	logic r_valid;
	logic r_ready;
	strm_beat_t strm;
	logic strm_valid;
	logic strm_ready = 1'b1;
	logic stall = 1'b0;
	logic random_bp;
	logic [ADDR_W-1:0] err_lo;
	logic [ADDR_W-1:0] err_hi;
	integer seed = 58;
	int cycles = 0;

	strm_beat_t rx_q[$];
	ar_req_t ar_q[$];

	mm2s_top #(
		.MAX_BURST(MAX_BURST),
		.FIFO_DEPTH(FIFO_DEPTH)
	) mm2s_top_inst (
		.clk(clk),
		.rst_n(rst_n),
		.trigger(trigger),
		.start_addr(start_addr),
		.bytes_to_read(bytes_to_read),
		.busy(busy),
		.response(response),
		.ar(ar),
		.ar_valid(ar_valid),
		.ar_ready(ar_ready),
		.r(r),
		.r_valid(r_valid),
		.r_ready(r_ready),
		.strm(strm),
		.strm_valid(strm_valid),
		.strm_ready(strm_ready)
	);

	axi_mem_model mem_inst (
		.clk(clk),
		.rst_n(rst_n),
		.stall(stall),
		.err_lo(err_lo),
		.err_hi(err_hi),
		.ar(ar),
		.ar_valid(ar_valid),
		.ar_ready(ar_ready),
		.r(r),
		.r_valid(r_valid),
		.r_ready(r_ready)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	always @(negedge clk) begin
		if (random_bp) begin
			strm_ready <= ($random(seed) & 1) != 0;
			stall <= ($random(seed) & 3) == 0;
		end else begin
			strm_ready <= 1'b1;
			stall <= 1'b0;
		end
	end

	// Stream beats and read requests as they are handed over
	always @(posedge clk) begin
		if (strm_valid && strm_ready) begin
			rx_q.push_back(strm);
		end
		if (ar_valid && ar_ready) begin
			ar_q.push_back(ar);
		end
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("Timeout: transfers did not complete within %0d cycles", TIMEOUT_CYCLES);
			$display("*** FAILED ***");
			$fatal(1, "simulation timed out");
		end
	end

	task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
			input string what);
		if (actual !== expected) begin
			$display("[FAIL] %0t: %s, got 0x%0h, expected 0x%0h", $time, what, actual, expected);
			$display("*** FAILED ***");
			$fatal(1, "value mismatch");
		end
	endtask

	function automatic logic [7:0] expected_byte(input logic [ADDR_W-1:0] a);
		return a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ 8'h5A;
	endfunction

	task automatic compare_stream(input logic [ADDR_W-1:0] addr, input int nbytes);
		int nbeats;
		int idx;
		nbeats = (nbytes + LANES - 1) / LANES;
		check_equal(rx_q.size(), nbeats, "stream beat count");
		for (int k = 0; k < nbeats; k++) begin
			for (int j = 0; j < LANES; j++) begin
				idx = k * LANES + j;
				check_equal(32'(rx_q[k].strb[j]), 32'(idx < nbytes),
					$sformatf("beat %0d lane %0d strobe", k, j));
				if (idx < nbytes) begin
					check_equal(32'(rx_q[k].data[8*j +: 8]), 32'(expected_byte(addr + ADDR_W'(idx))),
						$sformatf("beat %0d lane %0d data", k, j));
				end
			end
			check_equal(32'(rx_q[k].last), 32'(k == nbeats - 1), $sformatf("beat %0d last", k));
		end
	endtask

	task automatic audit_bursts(input logic [ADDR_W-1:0] addr, input int nbytes);
		logic [ADDR_W-1:0] next_addr;
		int beats;
		int page_off;
		int tail;
		int exp_size;
		next_addr = {addr[ADDR_W-1:LANE_W], {LANE_W{1'b0}}};
		check_equal(ar_q[0].addr, addr, "first burst address");
		foreach (ar_q[i]) begin
			beats = int'(ar_q[i].len) + 1;
			page_off = int'(next_addr[11:0]);
			// Bytes still wanted from the first word of this burst on
			tail = int'(addr + ADDR_W'(nbytes) - next_addr);
			exp_size = 0;
			while (exp_size < LANE_W && (1 << exp_size) < tail) begin
				exp_size++;
			end
			check_equal(32'(ar_q[i].size), 32'(exp_size), $sformatf("burst %0d size", i));
			check_equal(32'(beats <= 16), 1, $sformatf("burst %0d length", i));
			check_equal({ar_q[i].addr[ADDR_W-1:LANE_W], {LANE_W{1'b0}}}, next_addr,
				$sformatf("burst %0d start", i));
			check_equal(32'(page_off + beats * LANES <= 4096), 1,
				$sformatf("burst %0d crosses 4 KB", i));
			next_addr = next_addr + ADDR_W'(beats * LANES);
		end
		check_equal(32'(next_addr >= addr + ADDR_W'(nbytes)), 1, "bursts cover the transfer");
		check_equal(32'(next_addr < addr + ADDR_W'(nbytes + LANES)), 1, "excess beats requested");
	endtask

	task automatic start_transfer(input logic [ADDR_W-1:0] addr, input int nbytes);
		rx_q.delete();
		ar_q.delete();
		start_addr = addr;
		bytes_to_read = LEN_W'(nbytes);
		trigger = 1'b1;
		@(negedge clk);
		trigger = 1'b0;
		check_equal(32'(busy), 1, "busy after trigger");
		check_equal(32'(response), 32'(RESP_NONE), "response cleared at start");
	endtask

	task automatic finish_transfer(input logic [ADDR_W-1:0] addr, input int nbytes,
			input mm2s_resp_e resp);
		int nbeats;
		nbeats = (nbytes + LANES - 1) / LANES;
		while (busy || rx_q.size() < nbeats) begin
			@(negedge clk);
		end
		compare_stream(addr, nbytes);
		audit_bursts(addr, nbytes);
		check_equal(32'(response), 32'(resp), "completion response");
	endtask

	task automatic aligned_transfer();
		start_transfer(32'h100, 64);
		finish_transfer(32'h100, 64, RESP_OK);
	endtask

	task automatic unaligned_transfer();
		start_transfer(32'h203, 13);
		finish_transfer(32'h203, 13, RESP_OK);
	endtask

	task automatic burst_split();
		start_transfer(32'hFF8, 200);
		finish_transfer(32'hFF8, 200, RESP_OK);
	endtask

	// Longer than the FIFO so that a slow sink stalls r_ready
	task automatic back_pressure();
		random_bp = 1'b1;
		start_transfer(32'h1F6, 300);
		finish_transfer(32'h1F6, 300, RESP_OK);
		random_bp = 1'b0;
	endtask

	task automatic error_response();
		start_transfer(32'h7F0, 48);
		finish_transfer(32'h7F0, 48, RESP_SLVERR);
		start_transfer(32'h100, 32);
		finish_transfer(32'h100, 32, RESP_OK);
	endtask

	task automatic retrigger_ignored();
		int n_ar;
		start_transfer(32'h300, 40);
		repeat (4) @(negedge clk);
		check_equal(32'(busy), 1, "busy before second trigger");
		start_addr = 32'h500;
		bytes_to_read = 16'd8;
		trigger = 1'b1;
		@(negedge clk);
		trigger = 1'b0;
		finish_transfer(32'h300, 40, RESP_OK);
		n_ar = ar_q.size();
		repeat (40) @(negedge clk);
		check_equal(rx_q.size(), 10, "beats after ignored trigger");
		check_equal(ar_q.size(), n_ar, "requests after ignored trigger");
		check_equal(32'(busy), 0, "busy after ignored trigger");
	endtask

	initial begin
		rst_n = 1'b0;
		trigger = 1'b0;
		start_addr = '0;
		bytes_to_read = '0;
		random_bp = 1'b0;
		err_lo = 32'h800;
		err_hi = 32'h810;
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);
		check_equal(32'(busy), 0, "busy after reset");
		check_equal(32'(ar_valid), 0, "ar_valid after reset");
		check_equal(32'(r_ready), 0, "r_ready after reset");
		check_equal(32'(strm_valid), 0, "strm_valid after reset");
		check_equal(32'(response), 32'(RESP_NONE), "response after reset");

		aligned_transfer();
		unaligned_transfer();
		burst_split();
		back_pressure();
		error_response();
		retrigger_ignored();

		$display("*** PASSED ***");
		$finish;
	end

endmodule

`default_nettype wire

// File: flist.f
rtl/mm2s_pkg.sv
rtl/byte_lane_mux.sv
rtl/reg_slice.sv
rtl/stream_fifo.sv
rtl/mm2s_burst_planner.sv
rtl/mm2s_realigner.sv
rtl/mm2s_top.sv
dv/axi_mem_model.sv
dv/mm2s_tb.sv

// File: rtl/byte_lane_mux.sv
/*
	Byte lane multiplexer: picks a byte-offset slice of a two-word
	window, spreading the offset bits over STAGES register levels
*/
`timescale 1ns/1ps
`default_nettype none

module byte_lane_mux #(
	parameter int STAGES = 2
) (
	input logic clk,
	input logic rst_n,
	input logic enable,
	input logic [2*mm2s_pkg::DATA_W-1:0] window,
	input logic [mm2s_pkg::LANE_W-1:0] offset,
	output logic [mm2s_pkg::DATA_W-1:0] data
);
	import mm2s_pkg::*;

	logic [2*DATA_W-1:0] win_in [STAGES];
	logic [LANE_W-1:0] off_in [STAGES];

	assign win_in[0] = window;
	assign off_in[0] = offset;

	for (genvar s = 0; s < STAGES; s++) begin : g_stage
		logic [2*DATA_W-1:0] win_shift;

		// Offset bit b is applied in stage b mod STAGES
		always_comb begin
			win_shift = win_in[s];
			for (int b = 0; b < LANE_W; b++) begin
				if ((b % STAGES) == s && off_in[s][b]) begin
					win_shift = win_shift >> (8 << b);
				end
			end
		end

		if (s < STAGES - 1) begin : g_mid
			always_ff @(posedge clk) begin
				if (!rst_n) begin
					off_in[s+1] <= '0;
				end else if (enable) begin
					off_in[s+1] <= off_in[s];
				end
			end

			always_ff @(posedge clk) begin
				if (enable) begin
					win_in[s+1] <= win_shift;
				end
			end
		end else begin : g_last
			always_ff @(posedge clk) begin
				if (enable) begin
					data <= win_shift[DATA_W-1:0];
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: rtl/mm2s_burst_planner.sv
/*
	MM2S burst planner: drives the AXI read-address channel, splitting a
	transfer into bursts limited by MAX_BURST and the 4 KB boundary
*/
`timescale 1ns/1ps
`default_nettype none

module mm2s_burst_planner #(
	parameter int MAX_BURST = 15
) (
	input logic clk,
	input logic rst_n,
	input logic start,
	input logic [mm2s_pkg::ADDR_W-1:0] start_addr,
	input logic [mm2s_pkg::LEN_W-1:0] bytes_to_read,
	output mm2s_pkg::ar_req_t ar,
	output logic ar_valid,
	input logic ar_ready,
	output logic req_done
);
	import mm2s_pkg::*;

	typedef enum logic [1:0] {ST_IDLE, ST_SIZE, ST_LEN, ST_ADDR} state_e;

	state_e state;

	// Bytes left minus one, counted from the start of the current word
	logic [LEN_W:0] rem_m1;
	logic [LEN_W-LANE_W:0] beats_left_m1;
	logic [11:0] bytes_4k;
	logic [11-LANE_W:0] beats_4k_m1;
	logic [LEN_W:0] covered;
	logic [2:0] size_nxt;
	logic [7:0] len_b;
	logic [7:0] len_c;
	logic [7:0] len_min;

	always_comb begin
		beats_left_m1 = rem_m1[LEN_W:LANE_W];
		bytes_4k = 12'hFFF - ar.addr[11:0];
		beats_4k_m1 = bytes_4k[11:LANE_W];
		covered = (LEN_W + 1)'((32'(ar.len) + 1) << LANE_W);

		// Narrowest size that still holds the tail of a short transfer
		size_nxt = 3'(LANE_W);
		for (int s = LANE_W; s >= 0; s--) begin
			if (rem_m1 < (LEN_W + 1)'(1 << s)) begin
				size_nxt = 3'(s);
			end
		end

		len_min = 8'(MAX_BURST);
		if (len_b < len_min) begin
			len_min = len_b;
		end
		if (len_c < len_min) begin
			len_min = len_c;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= ST_IDLE;
			ar_valid <= 1'b0;
			req_done <= 1'b0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (start) begin
						state <= ST_SIZE;
						req_done <= 1'b0;
					end
				end
				ST_SIZE: begin
					state <= req_done ? ST_IDLE : ST_LEN;
				end
				ST_LEN: begin
					state <= ST_ADDR;
					ar_valid <= 1'b1;
				end
				ST_ADDR: begin
					if (ar_ready) begin
						state <= ST_SIZE;
						ar_valid <= 1'b0;
						req_done <= (rem_m1 < covered);
					end
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		case (state)
			ST_IDLE: begin
				if (start) begin
					ar.addr <= start_addr;
					rem_m1 <= {1'b0, bytes_to_read} + (LEN_W + 1)'(start_addr[LANE_W-1:0]) - 1'b1;
				end
			end
			ST_SIZE: begin
				ar.size <= size_nxt;
				len_b <= (beats_left_m1 > 'hFF) ? 8'hFF : beats_left_m1[7:0];
				len_c <= (beats_4k_m1 > 'hFF) ? 8'hFF : beats_4k_m1[7:0];
			end
			ST_LEN: begin
				ar.len <= len_min;
			end
			ST_ADDR: begin
				// Later bursts start on a word boundary
				if (ar_ready) begin
					ar.addr <= {ar.addr[ADDR_W-1:LANE_W] + (ADDR_W - LANE_W)'(ar.len) + 1'b1,
						{LANE_W{1'b0}}};
					rem_m1 <= rem_m1 - covered;
				end
			end
		endcase
	end

endmodule

`default_nettype wire

// File: rtl/mm2s_pkg.sv
/*
	MM2S read engine shared definitions: bus widths, packed beat
	structs and completion response codes
*/
`default_nettype none

package mm2s_pkg;

	localparam int DATA_W = 32;
	localparam int ADDR_W = 32;
	localparam int LANES = DATA_W / 8;
	localparam int LANE_W = $clog2(LANES);
	localparam int LEN_W = 16;

	// Ordered so that an error code compares above OK
	typedef enum logic [1:0] {
		RESP_NONE,
		RESP_OK,
		RESP_SLVERR,
		RESP_DECERR
	} mm2s_resp_e;

	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		logic [7:0] len;
		logic [2:0] size;
	} ar_req_t;

	typedef struct packed {
		logic [DATA_W-1:0] data;
		logic [1:0] resp;
		logic last;
	} r_beat_t;

	typedef struct packed {
		logic [DATA_W-1:0] data;
		logic [LANES-1:0] strb;
		logic last;
	} strm_beat_t;

	typedef struct packed {
		logic [LANES-1:0] strb;
		logic last;
		logic valid;
	} strm_side_t;

endpackage

`default_nettype wire

// File: rtl/mm2s_realigner.sv
/*
	MM2S realigner: accepts read beats, tracks byte counts and the
	response, and builds the two-word shift window with strobes and last
*/
`timescale 1ns/1ps
`default_nettype none

module mm2s_realigner (
	input logic clk,
	input logic rst_n,
	input logic start,
	input logic [mm2s_pkg::ADDR_W-1:0] start_addr,
	input logic [mm2s_pkg::LEN_W-1:0] bytes_to_read,
	input logic ar_fire,
	input logic enable,
	input mm2s_pkg::r_beat_t r,
	input logic r_valid,
	output logic r_ready,
	output logic [2*mm2s_pkg::DATA_W-1:0] window,
	output logic [mm2s_pkg::LANE_W-1:0] offset,
	output mm2s_pkg::strm_side_t side,
	output mm2s_pkg::mm2s_resp_e response
);
	import mm2s_pkg::*;

	typedef enum logic [1:0] {S1_IDLE, S1_WAIT_REQ, S1_FETCH, S1_FLUSH} s1_state_e;

	s1_state_e s1_state;
	logic [LEN_W:0] bytes_in;
	logic [DATA_W-1:0] s1_data;
	logic s1_valid;

	logic s2_active;
	logic s2_first;
	logic s2_drop;
	logic s2_emit;
	logic [LEN_W-1:0] bytes_out;

	assign r_ready = (s1_state == S1_FETCH) && enable;

	// First word only fills the window when the start offset spills into a second word
	assign s2_emit = !(s2_first && s2_drop);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			s1_state <= S1_IDLE;
			s1_valid <= 1'b0;
			response <= RESP_NONE;
		end else begin
			case (s1_state)
				S1_IDLE: begin
					s1_valid <= 1'b0;
					if (start) begin
						s1_state <= S1_WAIT_REQ;
						response <= RESP_NONE;
					end
				end
				S1_WAIT_REQ: begin
					if (ar_fire) begin
						s1_state <= S1_FETCH;
					end
				end
				S1_FETCH: begin
					if (enable) begin
						s1_valid <= r_valid;
						if (r_valid) begin
							if (response == RESP_NONE || response == RESP_OK) begin
								case (r.resp)
									2'b10: response <= RESP_SLVERR;
									2'b11: response <= RESP_DECERR;
									default: response <= RESP_OK;
								endcase
							end
							if (r.last && bytes_in <= (LEN_W + 1)'(LANES)) begin
								s1_state <= S1_FLUSH;
							end
						end
					end
				end
				S1_FLUSH: begin
					// Zero beats push the final word through the window
					if (!s2_active) begin
						s1_state <= S1_IDLE;
						s1_valid <= 1'b0;
					end else if (enable) begin
						s1_valid <= 1'b1;
					end
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (start && s1_state == S1_IDLE) begin
			bytes_in <= {1'b0, bytes_to_read} + (LEN_W + 1)'(start_addr[LANE_W-1:0]);
		end else if (r_ready && r_valid) begin
			bytes_in <= bytes_in - (LEN_W + 1)'(LANES);
		end

		if (r_ready) begin
			s1_data <= r.data;
		end else if (s1_state == S1_FLUSH && enable) begin
			s1_data <= '0;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			s2_active <= 1'b0;
			s2_first <= 1'b0;
			side <= '0;
		end else begin
			if (enable) begin
				side.valid <= 1'b0;
				side.last <= 1'b0;
				if (s2_active && s1_valid) begin
					s2_first <= 1'b0;
					if (s2_emit) begin
						side.valid <= 1'b1;
						side.last <= (bytes_out <= LEN_W'(LANES));
						for (int i = 0; i < LANES; i++) begin
							side.strb[i] <= (bytes_out > LEN_W'(i));
						end
						if (bytes_out <= LEN_W'(LANES)) begin
							s2_active <= 1'b0;
						end
					end
				end
			end
			if (start) begin
				s2_active <= 1'b1;
				s2_first <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			bytes_out <= bytes_to_read;
			offset <= start_addr[LANE_W-1:0];
			s2_drop <= ({1'b0, bytes_to_read} + (LEN_W + 1)'(start_addr[LANE_W-1:0]))
				> (LEN_W + 1)'(LANES);
		end else if (enable && s2_active && s1_valid) begin
			// Duplicating the first word avoids a separate load path
			window <= s2_first ? {s1_data, s1_data} : {s1_data, window[2*DATA_W-1:DATA_W]};
			if (s2_emit) begin
				bytes_out <= bytes_out - LEN_W'(LANES);
			end
		end
	end

endmodule

`default_nettype wire

// File: rtl/mm2s_top.sv
/*
	MM2S read engine top: busy tracking and the path from AXI read
	bursts through realignment to the output stream FIFO
*/
`timescale 1ns/1ps
`default_nettype none

module mm2s_top #(
	parameter int MAX_BURST = 15,
	parameter int FIFO_DEPTH = 16
) (
	input logic clk,
	input logic rst_n,
	input logic trigger,
	input logic [mm2s_pkg::ADDR_W-1:0] start_addr,
	input logic [mm2s_pkg::LEN_W-1:0] bytes_to_read,
	output logic busy,
	output mm2s_pkg::mm2s_resp_e response,
	output mm2s_pkg::ar_req_t ar,
	output logic ar_valid,
	input logic ar_ready,
	input mm2s_pkg::r_beat_t r,
	input logic r_valid,
	output logic r_ready,
	output mm2s_pkg::strm_beat_t strm,
	output logic strm_valid,
	input logic strm_ready
);
	import mm2s_pkg::*;

	localparam int STAGES = LANE_W;

	logic start;
	logic req_done;
	logic rd_done;
	logic ar_fire;
	logic enable;
	logic fifo_in_ready;
	logic [2*DATA_W-1:0] window;
	logic [LANE_W-1:0] offset;
	logic [DATA_W-1:0] mux_data;
	strm_side_t side;
	strm_side_t side_dly;
	strm_beat_t fifo_in;

	assign start = trigger && !busy;
	assign ar_fire = ar_valid && ar_ready;
	// Pipeline moves when the FIFO takes the head beat or the head is empty
	assign enable = fifo_in_ready || !side_dly.valid;
	assign fifo_in = '{data: mux_data, strb: side_dly.strb, last: side_dly.last};

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			busy <= 1'b0;
			rd_done <= 1'b0;
		end else begin
			if (!busy) begin
				busy <= trigger;
				rd_done <= 1'b0;
			end else begin
				busy <= !(req_done && rd_done);
				if (side_dly.valid && side_dly.last && fifo_in_ready) begin
					rd_done <= 1'b1;
				end
			end
		end
	end

	mm2s_burst_planner #(
		.MAX_BURST(MAX_BURST)
	) planner_inst (
		.clk(clk),
		.rst_n(rst_n),
		.start(start),
		.start_addr(start_addr),
		.bytes_to_read(bytes_to_read),
		.ar(ar),
		.ar_valid(ar_valid),
		.ar_ready(ar_ready),
		.req_done(req_done)
	);

	mm2s_realigner realigner_inst (
		.clk(clk),
		.rst_n(rst_n),
		.start(start),
		.start_addr(start_addr),
		.bytes_to_read(bytes_to_read),
		.ar_fire(ar_fire),
		.enable(enable),
		.r(r),
		.r_valid(r_valid),
		.r_ready(r_ready),
		.window(window),
		.offset(offset),
		.side(side),
		.response(response)
	);

	byte_lane_mux #(
		.STAGES(STAGES)
	) mux_inst (
		.clk(clk),
		.rst_n(rst_n),
		.enable(enable),
		.window(window),
		.offset(offset),
		.data(mux_data)
	);

	reg_slice #(
		.payload_t(strm_side_t),
		.STAGES(STAGES)
	) side_slice_inst (
		.clk(clk),
		.rst_n(rst_n),
		.enable(enable),
		.din(side),
		.dout(side_dly)
	);

	stream_fifo #(
		.payload_t(strm_beat_t),
		.DEPTH(FIFO_DEPTH)
	) fifo_inst (
		.clk(clk),
		.rst_n(rst_n),
		.in_data(fifo_in),
		.in_valid(side_dly.valid),
		.in_ready(fifo_in_ready),
		.out_data(strm),
		.out_valid(strm_valid),
		.out_ready(strm_ready)
	);

endmodule

`default_nettype wire

// File: rtl/reg_slice.sv
/*
	Register delay line of STAGES entries for any payload type,
	advancing only while enable is high
*/
`timescale 1ns/1ps
`default_nettype none

module reg_slice #(
	parameter type payload_t = logic,
	parameter int STAGES = 2
) (
	input logic clk,
	input logic rst_n,
	input logic enable,
	input payload_t din,
	output payload_t dout
);

	payload_t pipe [STAGES];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < STAGES; i++) begin
				pipe[i] <= '0;
			end
		end else if (enable) begin
			pipe[0] <= din;
			for (int i = 1; i < STAGES; i++) begin
				pipe[i] <= pipe[i-1];
			end
		end
	end

	assign dout = pipe[STAGES-1];

endmodule

`default_nettype wire

// File: rtl/stream_fifo.sv
/*
	Synchronous FIFO with valid/ready on both sides, built as a
	circular buffer with an occupancy count
*/
`timescale 1ns/1ps
`default_nettype none

module stream_fifo #(
	parameter type payload_t = logic,
	parameter int DEPTH = 16
) (
	input logic clk,
	input logic rst_n,
	input payload_t in_data,
	input logic in_valid,
	output logic in_ready,
	output payload_t out_data,
	output logic out_valid,
	input logic out_ready
);
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	payload_t mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic push;
	logic pop;

	assign in_ready = (count != CNT_W'(DEPTH));
	assign out_valid = (count != '0);
	assign push = in_valid && in_ready;
	assign pop = out_valid && out_ready;
	assign out_data = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr] <= in_data;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push) begin
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

`default_nettype wire
